// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - mem_stage_pkg.sv
      - mem_access_ctrl.sv
      - load_align.sv
      - store_format.sv
      - stage_reg.sv
      - mem_stage.sv
  - target: test
    files:
      - tb_mem_stage.sv

// File: list.f
mem_stage_pkg.sv
mem_access_ctrl.sv
load_align.sv
store_format.sv
stage_reg.sv
mem_stage.sv
tb_mem_stage.sv

// File: load_align.sv
`default_nettype none

module load_align import mem_stage_pkg::*; (
  input  wire mem_op_e     op,
  input  wire [2:0]        offset,
  input  wire [XLEN-1:0]   rdata,
  output logic [XLEN-1:0]  mdata
);

  logic [1:0]      size;
  logic [2:0]      lane;
  logic [XLEN-1:0] shifted;

  assign size = access_size(op);

  // Low address bits below the access size are ignored
  always_comb begin
    case (size)
      2'd0:    lane = offset;
      2'd1:    lane = {offset[2:1], 1'b0};
      2'd2:    lane = {offset[2], 2'b00};
      default: lane = 3'b000;
    endcase
  end

  assign shifted = rdata >> {lane, 3'b000};

  always_comb begin
    case (op)
      op_lb:   mdata = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      op_lbu:  mdata = {{(XLEN-8){1'b0}}, shifted[7:0]};
      op_lh:   mdata = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      op_lhu:  mdata = {{(XLEN-16){1'b0}}, shifted[15:0]};
      op_lw:   mdata = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
      op_lwu:  mdata = {{(XLEN-32){1'b0}}, shifted[31:0]};
      op_ld:   mdata = shifted;
      default: mdata = '0;    // Not a load
    endcase
  end

endmodule

`default_nettype wire

// File: mem_access_ctrl.sv
`default_nettype none

module mem_access_ctrl import mem_stage_pkg::*; (
  input  wire              clk,
  input  wire              reset,
  input  wire              in_enable,
  input  wire              syscall_flush,
  input  wire mem_op_e     op,
  input  wire [XLEN-1:0]   vaddr,
  input  wire [XLEN-1:0]   store_data,
  input  wire [7:0]        store_mask,
  input  wire              xlate_ack,
  input  wire [XLEN-1:0]   xlate_paddr,
  input  wire              cache_ack,
  input  wire [XLEN-1:0]   cache_rdata,
  output logic             xlate_req,
  output logic [XLEN-1:0]  xlate_vaddr,
  output logic             cache_req,
  output mem_req_t         cache_cmd,
  output logic [XLEN-1:0]  held_rdata,
  output logic [XLEN-1:0]  held_paddr,
  output logic             ready
);

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic        mem_op;
  logic        store_op;

  assign store_op = is_store(op);
  assign mem_op   = is_load(op) || store_op;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (in_enable && mem_op) state_next = st_xlate;
      end
      st_xlate: begin
        if (xlate_ack) state_next = st_access;
      end
      st_access: begin
        if (cache_ack) state_next = st_done;
      end
      st_done: begin
        state_next = st_idle; // Result handed over this cycle
      end
      default: begin
        state_next = st_idle;
      end
    endcase
    if (syscall_flush) begin
      state_next = st_idle;   // Abandon any outstanding access
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_xlate && xlate_ack) begin
      held_paddr <= xlate_paddr;
    end
    if (state == st_access && cache_ack) begin
      held_rdata <= cache_rdata;
    end
  end

  assign xlate_req   = (state == st_xlate) && !syscall_flush;
  assign cache_req   = (state == st_access) && !syscall_flush;
  assign xlate_vaddr = {vaddr[XLEN-1:3], 3'b000};

  // Inputs are held by upstream, so the command stays steady
  always_comb begin
    cache_cmd.paddr = {held_paddr[XLEN-1:3], 3'b000};
    cache_cmd.write = store_op;
    cache_cmd.wdata = store_op ? store_data : '0;
    cache_cmd.wmask = store_op ? store_mask : 8'h00;
  end

  always_comb begin
    if (syscall_flush) begin
      ready = 1'b1;
    end else begin
      case (state)
        st_idle: ready = !mem_op; // Non-memory ops pass at once
        st_done: ready = 1'b1;
        default: ready = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: mem_stage.sv
`default_nettype none

module mem_stage import mem_stage_pkg::*; (
  input  wire              clk,
  input  wire              reset,
  input  wire              in_enable,
  input  wire              syscall_flush,
  input  wire stage_in_t   instr_in,
  output logic             out_ready,
  output logic             xlate_req,
  output logic [XLEN-1:0]  xlate_vaddr,
  input  wire              xlate_ack,
  input  wire [XLEN-1:0]   xlate_paddr,
  output logic             cache_req,
  output mem_req_t         cache_cmd,
  input  wire              cache_ack,
  input  wire [XLEN-1:0]   cache_rdata,
  output stage_out_t       result
);

  logic [XLEN-1:0] held_rdata;
  logic [XLEN-1:0] held_paddr;
  logic [XLEN-1:0] mdata;
  logic [XLEN-1:0] wdata;
  logic [7:0]      wmask;
  logic            stage_load;

  // Accept only when the stage is ready and nothing is flushed
  assign stage_load = in_enable && out_ready && !syscall_flush;

  store_format u_store_format (
    .op     (instr_in.op),
    .offset (instr_in.alu_result[2:0]),
    .value  (instr_in.rs2_value),
    .wdata  (wdata),
    .wmask  (wmask)
  );

  mem_access_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .in_enable     (in_enable),
    .syscall_flush (syscall_flush),
    .op            (instr_in.op),
    .vaddr         (instr_in.alu_result),
    .store_data    (wdata),
    .store_mask    (wmask),
    .xlate_ack     (xlate_ack),
    .xlate_paddr   (xlate_paddr),
    .cache_ack     (cache_ack),
    .cache_rdata   (cache_rdata),
    .xlate_req     (xlate_req),
    .xlate_vaddr   (xlate_vaddr),
    .cache_req     (cache_req),
    .cache_cmd     (cache_cmd),
    .held_rdata    (held_rdata),
    .held_paddr    (held_paddr),
    .ready         (out_ready)
  );

  load_align u_load_align (
    .op     (instr_in.op),
    .offset (instr_in.alu_result[2:0]),
    .rdata  (held_rdata),
    .mdata  (mdata)
  );

  stage_reg u_stage_reg (
    .clk      (clk),
    .reset    (reset),
    .load     (stage_load),
    .instr    (instr_in),
    .mdata    (mdata),
    .phy_addr (held_paddr),
    .result   (result)
  );

endmodule

`default_nettype wire

// File: mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  localparam int XLEN    = 64;
  localparam int REGNO_W = 5;

  typedef enum logic [3:0] {
    op_none, // Any non-memory instruction
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_xlate,
    st_access,
    st_done
  } ctrl_state_e;

  typedef struct packed {
    mem_op_e            op;
    logic [XLEN-1:0]    alu_result; // Virtual address for loads and stores
    logic [XLEN-1:0]    rs2_value;
    logic [REGNO_W-1:0] rd_regno;
    logic               update_rd;
    logic               branch_taken;
    logic [XLEN-1:0]    pc_target;
  } stage_in_t;

  typedef struct packed {
    mem_op_e            op;
    logic [XLEN-1:0]    alu_result;
    logic [XLEN-1:0]    rs2_value;
    logic [REGNO_W-1:0] rd_regno;
    logic               update_rd;
    logic               branch_taken;
    logic [XLEN-1:0]    pc_target;
    logic [XLEN-1:0]    mdata;      // Extended load value
    logic [XLEN-1:0]    phy_addr;   // Translated address of a store
  } stage_out_t;

  typedef struct packed {
    logic [XLEN-1:0] paddr; // Doubleword aligned
    logic            write;
    logic [XLEN-1:0] wdata;
    logic [7:0]      wmask;
  } mem_req_t;

  function automatic logic is_load(mem_op_e op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  // log2 of the access size in bytes
  function automatic logic [1:0] access_size(mem_op_e op);
    case (op)
      op_lh, op_lhu, op_sh: return 2'd1;
      op_lw, op_lwu, op_sw: return 2'd2;
      op_ld, op_sd:         return 2'd3;
      default:              return 2'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: stage_reg.sv
`default_nettype none

module stage_reg import mem_stage_pkg::*; (
  input  wire              clk,
  input  wire              reset,
  input  wire              load,
  input  wire stage_in_t   instr,
  input  wire [XLEN-1:0]   mdata,
  input  wire [XLEN-1:0]   phy_addr,
  output stage_out_t       result
);

  stage_out_t next;

  always_comb begin
    next = '0;                 // Bubble unless loading
    if (load) begin
      next.op           = instr.op;
      next.alu_result   = instr.alu_result;
      next.rs2_value    = instr.rs2_value;
      next.rd_regno     = instr.rd_regno;
      next.update_rd    = instr.update_rd;
      next.branch_taken = instr.branch_taken;
      next.pc_target    = instr.pc_target;
      if (is_load(instr.op)) begin
        next.mdata = mdata;
      end
      if (is_store(instr.op)) begin
        next.phy_addr = phy_addr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else begin
      result <= next;
    end
  end

endmodule

`default_nettype wire

// File: store_format.sv
`default_nettype none

module store_format import mem_stage_pkg::*; (
  input  wire mem_op_e     op,
  input  wire [2:0]        offset,
  input  wire [XLEN-1:0]   value,
  output logic [XLEN-1:0]  wdata,
  output logic [7:0]       wmask
);

  logic [1:0] size;

  assign size = access_size(op);

  always_comb begin
    if (!is_store(op)) begin
      wdata = '0;
      wmask = 8'h00;
    end else begin
      case (size)
        2'd0: begin
          wdata = {8{value[7:0]}};
          wmask = 8'b0000_0001 << offset;
        end
        2'd1: begin
          wdata = {4{value[15:0]}};
          wmask = 8'b0000_0011 << {offset[2:1], 1'b0};
        end
        2'd2: begin
          wdata = {2{value[31:0]}};
          wmask = 8'b0000_1111 << {offset[2], 2'b00};
        end
        default: begin
          wdata = value;
          wmask = 8'hff;       // Whole doubleword
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tb_mem_stage.sv
`default_nettype none

module tb_mem_stage import mem_stage_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          PERIOD       = 40;
  localparam int          NUM_DIRECTED = 88;   // 11 ops at 8 offsets
  localparam int          NUM_RANDOM   = 300;
  localparam int          MAX_CYCLES   = 32;   // Two attempts with the longest ack delays
  localparam int          TIMEOUT_NS   = (NUM_DIRECTED + NUM_RANDOM + 20) * MAX_CYCLES * PERIOD * 2;
  localparam logic [63:0] VBASE        = 64'h0000_0000_8000_1000;
  localparam logic [63:0] XLATE_KEY    = 64'h0000_00f0_0a50_0000;

  logic            clk = 1'b0;
  logic            reset;
  logic            in_enable;
  logic            syscall_flush;
  stage_in_t       instr_in;
  logic            out_ready;
  logic            xlate_req;
  logic [XLEN-1:0] xlate_vaddr;
  logic            xlate_ack;
  logic [XLEN-1:0] xlate_paddr;
  logic            cache_req;
  mem_req_t        cache_cmd;
  logic            cache_ack;
  logic [XLEN-1:0] cache_rdata;
  stage_out_t      result;

  logic [XLEN-1:0] cache_mem [32];  // Behind the cache port
  logic [XLEN-1:0] model_mem [32];  // Reference copy
  stage_out_t      expected_q [$];
  mem_req_t        exp_cmd;
  int              xlate_delay;
  int              cache_delay;
  logic [31:0]     rng_state = 32'd94112;
  int              errors = 0;
  int              results = 0;
  int              flushes = 0;

  mem_stage uut (.*);

  always #(PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] paddr);
    return {paddr[31:0] * 32'h9e37_79b9, paddr[63:32] ^ {paddr[15:0], paddr[31:16]}};
  endfunction

  function automatic logic op_loads(input mem_op_e op);
    return op >= op_lb && op <= op_ld;
  endfunction

  function automatic logic op_stores(input mem_op_e op);
    return op >= op_sb;
  endfunction

  function automatic int unsigned op_bytes(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] lane_value(input mem_op_e op, input logic [2:0] offset,
                                                 input logic [XLEN-1:0] dword);
    int unsigned     nbytes;
    logic [XLEN-1:0] keep;
    logic [XLEN-1:0] value;
    nbytes = op_bytes(op);
    value  = dword >> (8 * (offset - (offset % nbytes)));
    if (nbytes < 8) begin
      keep  = (64'd1 << (8 * nbytes)) - 64'd1;
      value = value & keep;
      if ((op == op_lb || op == op_lh || op == op_lw) && value[8 * nbytes - 1]) begin
        value = value | ~keep;
      end
    end
    return value;
  endfunction

  function automatic mem_req_t expect_cmd(input stage_in_t ins);
    mem_req_t    cmd;
    int unsigned nbytes;
    logic [15:0] mask;
    cmd       = '0;
    nbytes    = op_bytes(ins.op);
    cmd.paddr = (ins.alu_result & ~64'h7) ^ XLATE_KEY;
    if (op_stores(ins.op)) begin
      cmd.write = 1'b1;
      for (int b = 0; b < 8; b++) begin
        cmd.wdata[8 * b +: 8] = ins.rs2_value[8 * (b % nbytes) +: 8]; // Value repeated per lane
      end
      mask      = ((16'd1 << nbytes) - 16'd1) << (ins.alu_result[2:0] - (ins.alu_result[2:0] % nbytes));
      cmd.wmask = mask[7:0];
    end
    return cmd;
  endfunction

  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old,
                                                  input logic [XLEN-1:0] data,
                                                  input logic [7:0] mask);
    logic [XLEN-1:0] merged;
    merged = old;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) merged[8 * b +: 8] = data[8 * b +: 8];
    end
    return merged;
  endfunction

  function automatic stage_in_t make_instr(input mem_op_e op, input logic [XLEN-1:0] addr);
    stage_in_t ins;
    ins.op           = op;
    ins.alu_result   = addr;
    ins.rs2_value    = {next_rand(), next_rand()};
    ins.rd_regno     = REGNO_W'(next_rand());
    ins.update_rd    = 1'(next_rand());
    ins.branch_taken = 1'(next_rand());
    ins.pc_target    = {next_rand(), next_rand()};
    return ins;
  endfunction

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic check_result(input stage_out_t got, input stage_out_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED result: got %h, expected %h at %0t ns", got, exp, $time);
    end
  endtask

  task automatic check_cmd(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED cache_cmd: got %h, expected %h at %0t ns", got, exp, $time);
    end
  endtask

  // Presents one instruction and holds it until the stage takes it
  task automatic run_instr(input stage_in_t ins, input int flush_after);
    int         waited;
    logic       done;
    stage_out_t exp;
    waited      = 0;
    done        = 1'b0;
    instr_in    = ins;
    in_enable   = 1'b1;
    exp_cmd     = expect_cmd(ins);
    xlate_delay = next_rand() % 4;
    cache_delay = next_rand() % 4;
    while (!done) begin
      @(posedge clk);
      if (waited == 0) check_word("out_ready", out_ready, ins.op == op_none);
      if (ins.op == op_none || syscall_flush) begin
        check_word("xlate_req", xlate_req, 0);
        check_word("cache_req", cache_req, 0);
      end
      if (out_ready && !syscall_flush) begin
        exp = '0;
        exp.op           = ins.op;
        exp.alu_result   = ins.alu_result;
        exp.rs2_value    = ins.rs2_value;
        exp.rd_regno     = ins.rd_regno;
        exp.update_rd    = ins.update_rd;
        exp.branch_taken = ins.branch_taken;
        exp.pc_target    = ins.pc_target;
        if (op_loads(ins.op)) begin
          exp.mdata = lane_value(ins.op, ins.alu_result[2:0], model_mem[ins.alu_result[7:3]]);
        end
        if (op_stores(ins.op)) begin
          exp.phy_addr = exp_cmd.paddr;
          model_mem[ins.alu_result[7:3]] = merge_bytes(model_mem[ins.alu_result[7:3]],
                                                       exp_cmd.wdata, exp_cmd.wmask);
        end
        expected_q.push_back(exp);
        done = 1'b1;
      end
      @(negedge clk);
      if (syscall_flush) begin
        syscall_flush = 1'b0;       // Instruction stays presented for the retry
      end else if (!done && waited + 1 == flush_after && (xlate_req || cache_req)) begin
        syscall_flush = 1'b1;
        flushes++;
      end
      waited++;
    end
  endtask

  initial begin : stimulus
    stage_in_t ins;
    mem_op_e   op;
    int        flush_after;
    reset         = 1'b1;
    in_enable     = 1'b0;
    syscall_flush = 1'b0;
    instr_in      = '0;
    exp_cmd       = '0;
    for (int i = 0; i < 32; i++) begin
      cache_mem[i] = fill_word((VBASE ^ XLATE_KEY) + 64'(8 * i));
      model_mem[i] = fill_word((VBASE ^ XLATE_KEY) + 64'(8 * i));
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (3) begin
      @(posedge clk);
      check_word("xlate_req", xlate_req, 0);
      check_word("cache_req", cache_req, 0);
    end
    @(negedge clk);
    for (int k = 0; k < 11; k++) begin   // All stores, then all loads
      op = (k < 4) ? mem_op_e'(op_sb + k) : mem_op_e'(op_lb + k - 4);
      for (int off = 0; off < 8; off++) begin
        run_instr(make_instr(op, VBASE + 64'(8 * (next_rand() % 32) + off)), 0);
      end
    end
    for (int n = 0; n < NUM_RANDOM; n++) begin
      op = mem_op_e'(next_rand() % 12);
      if (op == op_none) ins = make_instr(op, {next_rand(), next_rand()});
      else ins = make_instr(op, VBASE + 64'(next_rand() % 256));
      flush_after = (op != op_none && next_rand() % 6 == 0) ? 1 + next_rand() % 4 : 0;
      run_instr(ins, flush_after);
      repeat (next_rand() % 3) begin
        in_enable = 1'b0;                // Idle cycle with junk on the bus
        instr_in  = make_instr(mem_op_e'(next_rand() % 12), {next_rand(), next_rand()});
        @(negedge clk);
      end
    end
    in_enable = 1'b0;
    repeat (3) @(negedge clk);
    if (expected_q.size() != 0) begin
      errors++;
      $display("%0d accepted instructions never showed up in result", expected_q.size());
    end
    for (int i = 0; i < 32; i++) begin
      check_word($sformatf("cache_mem[%0d]", i), cache_mem[i], model_mem[i]);
    end
    $display("Results checked: %0d, flushes: %0d, errors: %0d", results, flushes, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : xlate_responder
    logic [XLEN-1:0] vaddr;
    int              wait_cycles;
    logic            live;
    xlate_ack   = 1'b0;
    xlate_paddr = '0;
    forever begin
      @(posedge clk);
      if (xlate_req) begin
        vaddr = xlate_vaddr;
        check_word("xlate_vaddr", vaddr, exp_cmd.paddr ^ XLATE_KEY);
        wait_cycles = xlate_delay;
        live        = 1'b1;
        while (live && wait_cycles > 0) begin
          @(posedge clk);
          live = xlate_req;              // Low after a flush
          wait_cycles--;
        end
        if (live) begin
          @(negedge clk);
          xlate_paddr = vaddr ^ XLATE_KEY;
          xlate_ack   = 1'b1;
          @(negedge clk);
          xlate_ack   = 1'b0;
        end
      end
    end
  end

  initial begin : cache_responder
    mem_req_t   cmd;
    int         wait_cycles;
    logic       live;
    logic [4:0] index;
    cache_ack   = 1'b0;
    cache_rdata = '0;
    forever begin
      @(posedge clk);
      if (cache_req) begin
        cmd   = cache_cmd;
        index = cmd.paddr[7:3];
        check_cmd(cmd, exp_cmd);
        wait_cycles = cache_delay;
        live        = 1'b1;
        while (live && wait_cycles > 0) begin
          @(posedge clk);
          live = cache_req;
          wait_cycles--;
        end
        if (live) begin
          @(negedge clk);
          cache_rdata = cmd.write ? '0 : cache_mem[index];
          cache_ack   = 1'b1;
          @(posedge clk);
          if (cache_req && cmd.write) begin  // Write lands only if the ack was taken
            cache_mem[index] = merge_bytes(cache_mem[index], cmd.wdata, cmd.wmask);
          end
          @(negedge clk);
          cache_ack = 1'b0;
        end
      end
    end
  end

  initial begin : result_monitor
    stage_out_t exp;
    wait (reset == 1'b0);
    forever begin
      @(negedge clk);
      if (expected_q.size() > 0) begin
        exp = expected_q.pop_front();
        results++;
      end else begin
        exp = '0;                        // Bubble
      end
      check_result(result, exp);
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
